// File: verilog/bp_pkg.sv
// branch predictor package
// sizes, counter codes, branch opcode fields and the program counter views

package bp_pkg;

    ////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////

    localparam int xlen       = 32;
    localparam int btb_len    = 16;
    localparam int index_bits = $clog2(btb_len);   // 4
    localparam int tag_bits   = xlen - index_bits; // 28

    ////////////////////////////////////////////////////////////////////
    // 2-bit saturating counter codes
    ////////////////////////////////////////////////////////////////////

    localparam logic [1:0] ctr_not_taken      = 2'd0;
    localparam logic [1:0] ctr_weak_not_taken = 2'd1;
    localparam logic [1:0] ctr_weak_taken     = 2'd2; // lowest taken code
    localparam logic [1:0] ctr_taken          = 2'd3;

    ////////////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////////////

    localparam logic [6:0] opcode_branch = 7'b1100011;

    // condition selectors in funct3
    localparam logic [2:0] funct3_beq  = 3'd0;
    localparam logic [2:0] funct3_bne  = 3'd1;
    localparam logic [2:0] funct3_blt  = 3'd4;
    localparam logic [2:0] funct3_bge  = 3'd5;
    localparam logic [2:0] funct3_bltu = 3'd6;
    localparam logic [2:0] funct3_bgeu = 3'd7;

    ////////////////////////////////////////////////////////////////////
    // program counter read as one address or as tag plus index
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [tag_bits-1:0]   tag;
        logic [index_bits-1:0] index;   // low bits select the entry
    } pc_split_t;

    typedef union packed {
        logic [xlen-1:0] raw;
        pc_split_t       split;
    } pc_addr_t;

endpackage

// File: verilog/branch_decode.sv
`timescale 1ns/1ns
// branch decode
// picks conditional branches out of decode and requests a buffer entry

module branch_decode import bp_pkg::*; (
    input  logic            decode_valid,
    input  logic [xlen-1:0] decode_pc,
    input  logic [31:0]     decode_instr,
    output logic            alloc_valid,
    output logic [xlen-1:0] alloc_pc
);

    logic [6:0] opcode;
    logic       is_branch;

    // major opcode sits in the low seven bits
    assign opcode = decode_instr[6:0];

    // only conditional branches so jumps and alu ops never
    // push an entry out of the buffer
    assign is_branch = (opcode == opcode_branch);

    always_comb begin
        alloc_valid = 1'b0;
        if (decode_valid && is_branch) begin
            alloc_valid = 1'b1;
        end
    end

    // buffer splits the address itself
    assign alloc_pc = decode_pc;

endmodule

// File: verilog/btb.sv
`timescale 1ns/1ns
// branch target buffer, direct mapped
// same-cycle lookup, allocation from decode, training from execute

module btb import bp_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic            fetch_valid,
    input  logic [xlen-1:0] fetch_pc,
    input  logic            alloc_valid,
    input  logic [xlen-1:0] alloc_pc,
    input  logic            update_valid,
    input  logic [xlen-1:0] update_pc,
    input  logic            update_taken,
    input  logic [xlen-1:0] update_target,
    output logic            pred_hit,
    output logic            pred_taken,
    output logic [xlen-1:0] pred_target
);

    // entry state
    logic                busy        [btb_len];
    logic [tag_bits-1:0] tags        [btb_len];
    logic [1:0]          ctrs        [btb_len];
    logic [xlen-1:0]     targets     [btb_len];

    logic                busy_next   [btb_len];
    logic [tag_bits-1:0] tags_next   [btb_len];
    logic [1:0]          ctrs_next   [btb_len];
    logic [xlen-1:0]     targets_next[btb_len];

    pc_addr_t fetch_addr;
    pc_addr_t alloc_addr;
    pc_addr_t update_addr;

    logic fetch_match;
    logic alloc_match;
    logic update_match;

    // one step toward the outcome with both ends sticky
    function automatic logic [1:0] ctr_step(input logic [1:0] ctr, input logic taken);
        logic [1:0] result;
        result = ctr;
        case (ctr)
            ctr_not_taken:      result = taken ? ctr_weak_not_taken : ctr_not_taken;
            ctr_weak_not_taken: result = taken ? ctr_weak_taken     : ctr_not_taken;
            ctr_weak_taken:     result = taken ? ctr_taken          : ctr_weak_not_taken;
            ctr_taken:          result = taken ? ctr_taken          : ctr_weak_taken;
            default:            result = ctr_not_taken;
        endcase
        return result;
    endfunction

    assign fetch_addr.raw  = fetch_pc;
    assign alloc_addr.raw  = alloc_pc;
    assign update_addr.raw = update_pc;

    // all matches use the state before the edge
    assign fetch_match  = busy[fetch_addr.split.index]
                        && (tags[fetch_addr.split.index] == fetch_addr.split.tag);
    assign alloc_match  = busy[alloc_addr.split.index]
                        && (tags[alloc_addr.split.index] == alloc_addr.split.tag);
    assign update_match = busy[update_addr.split.index]
                        && (tags[update_addr.split.index] == update_addr.split.tag);

    //////////////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        pred_hit    = 1'b0;
        pred_taken  = 1'b0;
        pred_target = '0;
        if (fetch_valid && fetch_match) begin
            pred_hit    = 1'b1;
            pred_taken  = (ctrs[fetch_addr.split.index] >= ctr_weak_taken);
            pred_target = targets[fetch_addr.split.index];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state, allocation then update
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        busy_next    = busy;
        tags_next    = tags;
        ctrs_next    = ctrs;
        targets_next = targets;

        // empty slot or another branch living there
        if (alloc_valid && !alloc_match) begin
            busy_next[alloc_addr.split.index]    = 1'b1;
            tags_next[alloc_addr.split.index]    = alloc_addr.split.tag;
            ctrs_next[alloc_addr.split.index]    = ctr_not_taken;
            targets_next[alloc_addr.split.index] = '0;
        end

        // written last so it wins on a shared index
        if (update_valid && update_match) begin
            targets_next[update_addr.split.index] = update_target;
            ctrs_next[update_addr.split.index]    =
                ctr_step(ctrs[update_addr.split.index], update_taken);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < btb_len; i++) begin
                busy[i]    <= 1'b0;
                tags[i]    <= '0;
                ctrs[i]    <= ctr_not_taken;
                targets[i] <= '0;
            end
        end else begin
            busy    <= busy_next;
            tags    <= tags_next;
            ctrs    <= ctrs_next;
            targets <= targets_next;
        end
    end

endmodule

// File: verilog/branch_resolve.sv
`timescale 1ns/1ns
// branch resolve
// computes direction and target in execute, trains the buffer, flags mispredicts

module branch_resolve import bp_pkg::*; (
    input  logic            ex_valid,
    input  logic [xlen-1:0] ex_pc,
    input  logic [31:0]     ex_instr,
    input  logic [xlen-1:0] ex_rs1_value,
    input  logic [xlen-1:0] ex_rs2_value,
    input  logic            ex_pred_taken,
    input  logic [xlen-1:0] ex_pred_target,
    output logic            update_valid,
    output logic [xlen-1:0] update_pc,
    output logic            update_taken,
    output logic [xlen-1:0] update_target,
    output logic            mispredict
);

    logic            is_branch;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] target;
    logic            cond;

    assign is_branch = ex_valid && (ex_instr[6:0] == opcode_branch);
    assign funct3    = ex_instr[14:12];

    // b-type immediate with bit 0 always zero
    assign imm = {{19{ex_instr[31]}}, ex_instr[31], ex_instr[7],
                  ex_instr[30:25], ex_instr[11:8], 1'b0};

    assign target = ex_pc + imm;

    always_comb begin
        case (funct3)
            funct3_beq:  cond = (ex_rs1_value == ex_rs2_value);
            funct3_bne:  cond = (ex_rs1_value != ex_rs2_value);
            funct3_blt:  cond = ($signed(ex_rs1_value) <  $signed(ex_rs2_value));
            funct3_bge:  cond = ($signed(ex_rs1_value) >= $signed(ex_rs2_value));
            funct3_bltu: cond = (ex_rs1_value <  ex_rs2_value);
            funct3_bgeu: cond = (ex_rs1_value >= ex_rs2_value);
            default:     cond = 1'b0;   // reserved encodings fall through
        endcase
    end

    // pulse on every resolved branch so the counter sees each outcome
    assign update_valid  = is_branch;
    assign update_pc     = ex_pc;
    assign update_taken  = is_branch && cond;
    assign update_target = is_branch ? target : '0;

    always_comb begin
        mispredict = 1'b0;
        if (is_branch) begin
            if (ex_pred_taken != cond) begin
                mispredict = 1'b1;                  // wrong direction
            end else if (cond && (ex_pred_target != target)) begin
                mispredict = 1'b1;                  // stale target
            end
        end
    end

endmodule

// File: verilog/bp_top.sv
`timescale 1ns/1ns
// branch predictor top
// decode allocation, target buffer and execute resolve wired together

module bp_top import bp_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    // fetch
    input  logic            fetch_valid,
    input  logic [xlen-1:0] fetch_pc,
    output logic            pred_hit,
    output logic            pred_taken,
    output logic [xlen-1:0] pred_target,
    // decode
    input  logic            decode_valid,
    input  logic [xlen-1:0] decode_pc,
    input  logic [31:0]     decode_instr,
    // execute
    input  logic            ex_valid,
    input  logic [xlen-1:0] ex_pc,
    input  logic [31:0]     ex_instr,
    input  logic [xlen-1:0] ex_rs1_value,
    input  logic [xlen-1:0] ex_rs2_value,
    input  logic            ex_pred_taken,
    input  logic [xlen-1:0] ex_pred_target,
    output logic            ex_taken,
    output logic [xlen-1:0] ex_target,
    output logic            ex_mispredict
);

    logic            alloc_valid;
    logic [xlen-1:0] alloc_pc;
    logic            update_valid;
    logic [xlen-1:0] update_pc;

    branch_decode i_branch_decode (
        .decode_valid (decode_valid),
        .decode_pc    (decode_pc),
        .decode_instr (decode_instr),
        .alloc_valid  (alloc_valid),
        .alloc_pc     (alloc_pc)
    );

    // resolved outcome doubles as the execute result
    branch_resolve i_branch_resolve (
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_instr       (ex_instr),
        .ex_rs1_value   (ex_rs1_value),
        .ex_rs2_value   (ex_rs2_value),
        .ex_pred_taken  (ex_pred_taken),
        .ex_pred_target (ex_pred_target),
        .update_valid   (update_valid),
        .update_pc      (update_pc),
        .update_taken   (ex_taken),
        .update_target  (ex_target),
        .mispredict     (ex_mispredict)
    );

    btb i_btb (
        .clock         (clock),
        .reset         (reset),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .alloc_valid   (alloc_valid),
        .alloc_pc      (alloc_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (ex_taken),
        .update_target (ex_target),
        .pred_hit      (pred_hit),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target)
    );

endmodule

// File: sim/bp_properties.sv
`timescale 1ns/1ns
// branch predictor port properties
// bound onto the top level to check strobe relations on the outside ports

module bp_properties (
    input logic clock,
    input logic reset,
    input logic fetch_valid,
    input logic pred_hit,
    input logic pred_taken,
    input logic ex_valid,
    input logic ex_mispredict
);

    // a hit needs a lookup
    hit_needs_fetch: assert property (
        @(posedge clock) disable iff (reset) pred_hit |-> fetch_valid
    ) else $error("pred_hit raised without fetch_valid");

    mispredict_needs_ex: assert property (
        @(posedge clock) disable iff (reset) ex_mispredict |-> ex_valid
    ) else $error("ex_mispredict raised without ex_valid");

    // buffer is empty right after reset
    no_hit_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> !pred_hit
    ) else $error("pred_hit high in the cycle after reset");

    taken_needs_hit: assert property (
        @(posedge clock) disable iff (reset) !pred_hit |-> !pred_taken
    ) else $error("pred_taken high without pred_hit");

endmodule

// File: sim/bp_tb.sv
`timescale 1ns/1ns
// branch predictor testbench
// table of fetch, decode and execute rows against hand-derived results

module bp_tb import bp_pkg::*;;

    typedef struct packed {
        logic        f_v;
        logic [31:0] f_pc;
        logic        d_v;
        logic [31:0] d_pc;
        logic [31:0] d_instr;
        logic        x_v;
        logic [31:0] x_pc;
        logic [31:0] x_instr;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        p_taken;
        logic [31:0] p_target;
        logic        e_hit;
        logic        e_ptaken;
        logic [31:0] e_ptarget;
        logic        e_xtaken;
        logic [31:0] e_xtarget;
        logic        e_mis;
    } row_t;

    localparam logic [31:0] pc_a   = 32'h0000_0100;  // index 0
    localparam logic [31:0] pc_b   = 32'h0000_0110;  // index 0 with another tag
    localparam logic [31:0] pc_c   = 32'h0000_0204;  // index 4
    localparam logic [31:0] nop    = 32'h0000_0013;
    localparam logic [31:0] m1     = 32'hffff_ffff;
    localparam int          timeout_cycles = 50;

    logic clock, reset;
    logic fetch_valid, pred_hit, pred_taken;
    logic [31:0] fetch_pc, pred_target;
    logic decode_valid;
    logic [31:0] decode_pc, decode_instr;
    logic ex_valid, ex_pred_taken, ex_taken, ex_mispredict;
    logic [31:0] ex_pc, ex_instr, ex_rs1_value, ex_rs2_value, ex_pred_target, ex_target;

    row_t  rows[$];
    string names[$];
    int    errors = 0;

    bp_top i_bp_top (.*);

    bind bp_top bp_properties i_bp_properties (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // b-type layout imm[12|10:5] rs2 rs1 funct3 imm[4:1|11] opcode
    function automatic logic [31:0] encode_branch(input logic [2:0] f3, input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], opcode_branch};
    endfunction

    task automatic check(input string name, input string field,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s %s expected %h actual %h", name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic add_row(input string name, input logic fv, input logic [31:0] fpc,
                           input logic dv, input logic [31:0] dpc, input logic [31:0] di,
                           input logic xv, input logic [31:0] xpc, input logic [31:0] xi,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic pt, input logic [31:0] ptgt,
                           input logic eh, input logic ept, input logic [31:0] eptgt,
                           input logic ext, input logic [31:0] extgt, input logic em);
        rows.push_back({fv, fpc, dv, dpc, di, xv, xpc, xi, a, b, pt, ptgt,
                        eh, ept, eptgt, ext, extgt, em});
        names.push_back(name);
    endtask

    // wait until the buffer and resolve outputs are quiet
    task automatic wait_quiet();
        int n;
        n = 0;
        while ((pred_hit !== 1'b0 || ex_mispredict !== 1'b0) && n < timeout_cycles) begin
            @(negedge clock);
            n++;
        end
        if (pred_hit !== 1'b0 || ex_mispredict !== 1'b0) begin
            $display("outputs never settled low after reset");
            errors++;
        end
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clock);
        fetch_valid    <= r.f_v;
        fetch_pc       <= r.f_pc;
        decode_valid   <= r.d_v;
        decode_pc      <= r.d_pc;
        decode_instr   <= r.d_instr;
        ex_valid       <= r.x_v;
        ex_pc          <= r.x_pc;
        ex_instr       <= r.x_instr;
        ex_rs1_value   <= r.rs1;
        ex_rs2_value   <= r.rs2;
        ex_pred_taken  <= r.p_taken;
        ex_pred_target <= r.p_target;
    endtask

    initial begin
        logic [31:0] beq_a, beq_b;
        row_t r;
        fetch_valid    <= 0;
        fetch_pc       <= 0;
        decode_valid   <= 0;
        decode_pc      <= 0;
        decode_instr   <= nop;
        ex_valid       <= 0;
        ex_pc          <= 0;
        ex_instr       <= nop;
        ex_rs1_value   <= 0;
        ex_rs2_value   <= 0;
        ex_pred_taken  <= 0;
        ex_pred_target <= 0;
        reset          <= 1'b1;

        beq_a = encode_branch(funct3_beq, 13'h040);  // +64
        beq_b = beq_a;

        //////////////////////////////////////////////////////////////////////
        // each row holds fetch, decode and execute inputs then expected results
        //////////////////////////////////////////////////////////////////////
        add_row("cold_a", 1, pc_a, 0, 0, nop, 0, 0, nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row("cold_other", 1, 32'h3fc, 0, 0, nop, 0, 0, nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row("alloc_a", 1, pc_a, 1, pc_a, beq_a, 0, 0, nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row("alloc_seen", 1, pc_a, 0, 0, nop, 0, 0, nop, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0);
        add_row("decode_nop", 1, pc_a, 1, pc_c, nop, 0, 0, nop, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0);
        add_row("nop_no_entry", 1, pc_c, 0, 0, nop, 0, 0, nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // taken outcomes walk the counter up
        add_row("train_1", 1, pc_a, 0, 0, nop, 1, pc_a, beq_a, 5, 5, 0, 0,
                1, 0, 0, 1, 32'h140, 1);
        add_row("train_2", 1, pc_a, 0, 0, nop, 1, pc_a, beq_a, 5, 5, 0, 0,
                1, 0, 32'h140, 1, 32'h140, 1);
        add_row("train_3", 1, pc_a, 0, 0, nop, 1, pc_a, beq_a, 5, 5, 1, 32'h140,
                1, 1, 32'h140, 1, 32'h140, 0);
        add_row("train_sat", 1, pc_a, 0, 0, nop, 1, pc_a, beq_a, 5, 5, 1, 32'h140,
                1, 1, 32'h140, 1, 32'h140, 0);
        // reallocating a live entry keeps its counter and target
        add_row("train_hold", 1, pc_a, 1, pc_a, beq_a, 0, 0, nop, 0, 0, 0, 0,
                1, 1, 32'h140, 0, 0, 0);
        // and not-taken outcomes walk it back
        add_row("untrain_1", 1, pc_a, 0, 0, nop, 1, pc_a, beq_a, 1, 2, 1, 32'h140,
                1, 1, 32'h140, 0, 32'h140, 1);
        add_row("untrain_2", 1, pc_a, 0, 0, nop, 1, pc_a, beq_a, 1, 2, 1, 32'h140,
                1, 1, 32'h140, 0, 32'h140, 1);
        add_row("untrain_3", 1, pc_a, 0, 0, nop, 1, pc_a, beq_a, 1, 2, 0, 0,
                1, 0, 32'h140, 0, 32'h140, 0);
        add_row("untrain_sat", 1, pc_a, 0, 0, nop, 1, pc_a, beq_a, 1, 2, 0, 0,
                1, 0, 32'h140, 0, 32'h140, 0);
        add_row("untrain_hold", 1, pc_a, 0, 0, nop, 0, 0, nop, 0, 0, 0, 0,
                1, 0, 32'h140, 0, 0, 0);
        // conditions at an unallocated address with offset -8
        add_row("beq_ne", 0, 0, 0, 0, nop, 1, pc_c, encode_branch(funct3_beq, -13'sd8),
                3, 4, 0, 0, 0, 0, 0, 0, 32'h1fc, 0);
        add_row("bne", 0, 0, 0, 0, nop, 1, pc_c, encode_branch(funct3_bne, -13'sd8),
                3, 4, 1, 32'h1fc, 0, 0, 0, 1, 32'h1fc, 0);
        add_row("blt_neg", 0, 0, 0, 0, nop, 1, pc_c, encode_branch(funct3_blt, -13'sd8),
                m1, 1, 1, 32'h1fc, 0, 0, 0, 1, 32'h1fc, 0);
        add_row("bltu_big", 0, 0, 0, 0, nop, 1, pc_c, encode_branch(funct3_bltu, -13'sd8),
                m1, 1, 0, 0, 0, 0, 0, 0, 32'h1fc, 0);
        add_row("bge_neg", 0, 0, 0, 0, nop, 1, pc_c, encode_branch(funct3_bge, -13'sd8),
                m1, 1, 0, 0, 0, 0, 0, 0, 32'h1fc, 0);
        add_row("bgeu_bad_tgt", 0, 0, 0, 0, nop, 1, pc_c, encode_branch(funct3_bgeu, -13'sd8),
                m1, 1, 1, 32'h200, 0, 0, 0, 1, 32'h1fc, 1);
        add_row("bge_equal", 0, 0, 0, 0, nop, 1, pc_c, encode_branch(funct3_bge, -13'sd8),
                7, 7, 1, 32'h1fc, 0, 0, 0, 1, 32'h1fc, 0);
        add_row("bltu_small", 0, 0, 0, 0, nop, 1, pc_c, encode_branch(funct3_bltu, -13'sd8),
                1, 2, 1, 32'h1fc, 0, 0, 0, 1, 32'h1fc, 0);
        add_row("ex_nop", 0, 0, 0, 0, nop, 1, pc_c, nop, 1, 1, 1, 32'h1fc,
                0, 0, 0, 0, 0, 0);
        // same index with another tag
        add_row("alias_alloc", 1, pc_a, 1, pc_b, beq_b, 0, 0, nop, 0, 0, 0, 0,
                1, 0, 32'h140, 0, 0, 0);
        add_row("alias_old", 1, pc_a, 0, 0, nop, 0, 0, nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row("alias_new", 1, pc_b, 0, 0, nop, 0, 0, nop, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0);
        add_row("tag_miss_upd", 1, pc_b, 0, 0, nop, 1, pc_a, beq_a, 5, 5, 0, 0,
                1, 0, 0, 1, 32'h140, 1);
        add_row("tag_miss_hold", 1, pc_b, 0, 0, nop, 0, 0, nop, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0);
        // alloc a over b while b trains and the update fields win
        add_row("collide", 1, pc_b, 1, pc_a, beq_a, 1, pc_b, beq_b, 5, 5, 0, 0,
                1, 0, 0, 1, 32'h150, 1);
        add_row("collide_new", 1, pc_a, 0, 0, nop, 1, pc_a, beq_a, 5, 5, 0, 0,
                1, 0, 32'h150, 1, 32'h140, 1);
        add_row("collide_old", 1, pc_b, 0, 0, nop, 0, 0, nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // one more taken step only reaches weak taken from the update's count
        add_row("collide_ctr", 1, pc_a, 0, 0, nop, 0, 0, nop, 0, 0, 0, 0,
                1, 1, 32'h140, 0, 0, 0);

        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        wait_quiet();

        foreach (rows[i]) begin
            r = rows[i];
            apply_row(r);
            @(negedge clock);
            check(names[i], "pred_hit", 32'(r.e_hit), 32'(pred_hit));
            check(names[i], "pred_taken", 32'(r.e_ptaken), 32'(pred_taken));
            check(names[i], "pred_target", r.e_ptarget, pred_target);
            check(names[i], "ex_taken", 32'(r.e_xtaken), 32'(ex_taken));
            check(names[i], "ex_target", r.e_xtarget, ex_target);
            check(names[i], "ex_mispredict", 32'(r.e_mis), 32'(ex_mispredict));
        end

        $display("rows: %0d errors: %0d", rows.size(), errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/bp_pkg.sv
verilog/branch_decode.sv
verilog/btb.sv
verilog/branch_resolve.sv
verilog/bp_top.sv
sim/bp_properties.sv
sim/bp_tb.sv

// File: Makefile
# Verilator build and run for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= bp_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
